// File: rate_pkg.sv
`default_nettype none

package rate_pkg;

    // Sequencer states, in the order the rate change walks them.
    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_TXDATA_WAIT,
        ST_PCLK_SEL,
        ST_DRP_X16_START,
        ST_DRP_X16_DONE,
        ST_RATE_SEL,
        ST_RXPMARESETDONE,
        ST_DRP_X20_START,
        ST_DRP_X20_DONE,
        ST_RATE_DONE,
        ST_TXSYNC_START,
        ST_TXSYNC_DONE,
        ST_DONE
    } rate_state_t;

    typedef enum logic [2:0]
    {
        DRP_IDLE,
        DRP_READ,
        DRP_READ_WAIT,
        DRP_WRITE,
        DRP_WRITE_WAIT,
        DRP_NEXT
    } drp_state_t;

    localparam logic [3:0] TXDATA_WAIT_MAX = 4'd15;    // Last count of the TX drain.

    localparam int DRP_ADDR_W = 9;
    localparam int DRP_DATA_W = 16;

    // TX_DATA_WIDTH and RX_DATA_WIDTH attributes, field at [13:11] in both.
    localparam logic [DRP_ADDR_W-1:0] DRP_TX_WIDTH_ADDR = 9'h06B;
    localparam logic [DRP_ADDR_W-1:0] DRP_RX_WIDTH_ADDR = 9'h011;
    localparam logic [DRP_DATA_W-1:0] WIDTH_FIELD_MASK  = 16'h3800;
    localparam logic [DRP_DATA_W-1:0] WIDTH_X16         = 16'h1000;   // Encoding 2.
    localparam logic [DRP_DATA_W-1:0] WIDTH_X20         = 16'h1800;   // Encoding 3.

    localparam logic [1:0] RATE_GEN1 = 2'd0;
    localparam logic [1:0] RATE_GEN2 = 2'd1;

endpackage

`default_nettype wire

// File: pipe_rate_ctrl.sv
`default_nettype none

module pipe_rate_ctrl
(
    input  wire                   RATE_CLK,
    input  wire                   RATE_RST_N,
    input  wire [1:0]             rate_in,
    input  wire                   drp_done,
    input  wire                   rxpmaresetdone,
    input  wire                   txratedone,
    input  wire                   rxratedone,
    input  wire                   phystatus,
    input  wire                   txsync_done,
    output logic                  pclk_sel,
    output logic                  drp_start,
    output logic                  drp_x16,
    output logic [2:0]            rate_out,
    output logic                  txsync_start,
    output logic                  rate_done,
    output logic                  rate_idle,
    output rate_pkg::rate_state_t rate_state
);

    import rate_pkg::*;

    rate_state_t state;

    logic [1:0] rate_in_s1;
    logic [1:0] rate_in_s2;
    logic       drp_done_s1;
    logic       drp_done_s2;
    logic       rxpmaresetdone_s1;
    logic       rxpmaresetdone_s2;
    logic       txratedone_s1;
    logic       txratedone_s2;
    logic       rxratedone_s1;
    logic       rxratedone_s2;
    logic       phystatus_s1;
    logic       phystatus_s2;
    logic       txsync_done_s1;
    logic       txsync_done_s2;

    logic [3:0] txdata_wait_cnt;
    logic       txratedone_flag;
    logic       rxratedone_flag;
    logic       phystatus_flag;
    logic       status_window;
    logic       all_rates_done;
    logic [2:0] rate_req;
    logic       req_seen;

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
        begin
            rate_in_s1        <= 2'd0;
            rate_in_s2        <= 2'd0;
            drp_done_s1       <= 1'b0;
            drp_done_s2       <= 1'b0;
            rxpmaresetdone_s1 <= 1'b0;
            rxpmaresetdone_s2 <= 1'b0;
            txratedone_s1     <= 1'b0;
            txratedone_s2     <= 1'b0;
            rxratedone_s1     <= 1'b0;
            rxratedone_s2     <= 1'b0;
            phystatus_s1      <= 1'b0;
            phystatus_s2      <= 1'b0;
            txsync_done_s1    <= 1'b0;
            txsync_done_s2    <= 1'b0;
        end
        else
        begin
            rate_in_s1        <= rate_in;
            rate_in_s2        <= rate_in_s1;
            drp_done_s1       <= drp_done;
            drp_done_s2       <= drp_done_s1;
            rxpmaresetdone_s1 <= rxpmaresetdone;
            rxpmaresetdone_s2 <= rxpmaresetdone_s1;
            txratedone_s1     <= txratedone;
            txratedone_s2     <= txratedone_s1;
            rxratedone_s1     <= rxratedone;
            rxratedone_s2     <= rxratedone_s1;
            phystatus_s1      <= phystatus;
            phystatus_s2      <= phystatus_s1;
            txsync_done_s1    <= txsync_done;
            txsync_done_s2    <= txsync_done_s1;
        end
    end

    assign rate_req = (rate_in_s2 == RATE_GEN2) ? 3'd1 : 3'd0;

    // A fresh edge, or a change that arrived while a sequence was running.
    assign req_seen = (rate_in_s2 != rate_in_s1) || (rate_req != rate_out);

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
            txdata_wait_cnt <= 4'd0;
        else if (state == ST_TXDATA_WAIT)
        begin
            if (txdata_wait_cnt != TXDATA_WAIT_MAX)
                txdata_wait_cnt <= txdata_wait_cnt + 4'd1;
        end
        else
            txdata_wait_cnt <= 4'd0;
    end

    assign status_window = (state == ST_RXPMARESETDONE) || (state == ST_DRP_X20_START) ||
                           (state == ST_DRP_X20_DONE) || (state == ST_RATE_DONE);

    // Rate-done pulses may land anywhere from PMA reset to the final wait.
    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N || !status_window)
        begin
            txratedone_flag <= 1'b0;
            rxratedone_flag <= 1'b0;
            phystatus_flag  <= 1'b0;
        end
        else
        begin
            txratedone_flag <= txratedone_flag | txratedone_s2;
            rxratedone_flag <= rxratedone_flag | rxratedone_s2;
            phystatus_flag  <= phystatus_flag | phystatus_s2;
        end
    end

    assign all_rates_done = txratedone_flag && rxratedone_flag && phystatus_flag;

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
        begin
            state    <= ST_IDLE;
            pclk_sel <= 1'b0;
            rate_out <= 3'd0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (req_seen)
                        state <= ST_TXDATA_WAIT;
                ST_TXDATA_WAIT:
                    if (txdata_wait_cnt == TXDATA_WAIT_MAX)
                        state <= ST_PCLK_SEL;
                ST_PCLK_SEL:
                begin
                    state    <= ST_DRP_X16_START;
                    pclk_sel <= (rate_in_s2 == RATE_GEN2);
                end
                ST_DRP_X16_START:
                    if (!drp_done_s2)
                        state <= ST_DRP_X16_DONE;    // Engine has taken the request.
                ST_DRP_X16_DONE:
                    if (drp_done_s2)
                        state <= ST_RATE_SEL;
                ST_RATE_SEL:
                begin
                    state    <= ST_RXPMARESETDONE;
                    rate_out <= rate_req;
                end
                ST_RXPMARESETDONE:
                    if (rxpmaresetdone_s1 && !rxpmaresetdone_s2)
                        state <= ST_DRP_X20_START;   // PMA reset finished.
                ST_DRP_X20_START:
                    if (!drp_done_s2)
                        state <= ST_DRP_X20_DONE;
                ST_DRP_X20_DONE:
                    if (drp_done_s2)
                        state <= ST_RATE_DONE;
                ST_RATE_DONE:
                    if (all_rates_done)
                        state <= ST_TXSYNC_START;
                ST_TXSYNC_START:
                    if (!txsync_done_s2)
                        state <= ST_TXSYNC_DONE;
                ST_TXSYNC_DONE:
                    if (txsync_done_s2)
                        state <= ST_DONE;
                ST_DONE:
                    state <= ST_IDLE;
                default:
                begin
                    state    <= ST_IDLE;
                    pclk_sel <= 1'b0;
                    rate_out <= 3'd0;
                end
            endcase
        end
    end

    assign drp_start    = (state == ST_DRP_X16_START) || (state == ST_DRP_X20_START);
    assign drp_x16      = (state == ST_DRP_X16_START) || (state == ST_DRP_X16_DONE);
    assign txsync_start = (state == ST_TXSYNC_START);
    assign rate_done    = (state == ST_DONE);
    assign rate_idle    = (state == ST_IDLE);
    assign rate_state   = state;

endmodule

`default_nettype wire

// File: drp_width_ctrl.sv
`default_nettype none

module drp_width_ctrl
(
    input  wire                               RATE_CLK,
    input  wire                               RATE_RST_N,
    input  wire                               drp_start,
    input  wire                               drp_x16,
    output logic                              drp_done,
    output logic [rate_pkg::DRP_ADDR_W-1:0]   drp_addr,
    output logic                              drp_en,
    output logic                              drp_we,
    output logic [rate_pkg::DRP_DATA_W-1:0]   drp_di,
    input  wire  [rate_pkg::DRP_DATA_W-1:0]   drp_do,
    input  wire                               drp_rdy
);

    import rate_pkg::*;

    drp_state_t state;

    logic                  x16_q;       // Width choice latched at start.
    logic                  reg_idx;     // 0 for TX, 1 for RX.
    logic [DRP_DATA_W-1:0] rd_data;
    logic [DRP_DATA_W-1:0] width_val;

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
        begin
            state   <= DRP_IDLE;
            x16_q   <= 1'b0;
            reg_idx <= 1'b0;
        end
        else
        begin
            case (state)
                DRP_IDLE:
                    if (drp_start)
                    begin
                        state   <= DRP_READ;
                        x16_q   <= drp_x16;
                        reg_idx <= 1'b0;
                    end
                DRP_READ:
                    state <= DRP_READ_WAIT;
                DRP_READ_WAIT:
                    if (drp_rdy)
                        state <= DRP_WRITE;
                DRP_WRITE:
                    state <= DRP_WRITE_WAIT;
                DRP_WRITE_WAIT:
                    if (drp_rdy)
                        state <= DRP_NEXT;
                DRP_NEXT:
                begin
                    if (reg_idx)
                        state <= DRP_IDLE;      // Both registers done.
                    else
                    begin
                        state   <= DRP_READ;
                        reg_idx <= 1'b1;
                    end
                end
                default:
                    state <= DRP_IDLE;
            endcase
        end
    end

    // Read data held for the modify step.
    always_ff @(posedge RATE_CLK)
    begin
        if ((state == DRP_READ_WAIT) && drp_rdy)
            rd_data <= drp_do;
    end

    assign width_val = x16_q ? WIDTH_X16 : WIDTH_X20;

    assign drp_addr = reg_idx ? DRP_RX_WIDTH_ADDR : DRP_TX_WIDTH_ADDR;
    assign drp_di   = (rd_data & ~WIDTH_FIELD_MASK) | width_val;
    assign drp_en   = (state == DRP_READ) || (state == DRP_WRITE);
    assign drp_we   = (state == DRP_WRITE);
    assign drp_done = (state == DRP_IDLE);

endmodule

`default_nettype wire

// File: txsync_ctrl.sv
`default_nettype none

module txsync_ctrl
(
    input  wire  RATE_CLK,
    input  wire  RATE_RST_N,
    input  wire  txsync_start,
    output logic txsync_done,
    output logic tx_phinit,
    output logic tx_phalign,
    input  wire  tx_phinitdone,
    input  wire  tx_phaligndone
);

    typedef enum logic [2:0]
    {
        TS_IDLE,
        TS_INIT,
        TS_INIT_WAIT,
        TS_ALIGN,
        TS_ALIGN_WAIT
    } txsync_state_t;

    txsync_state_t state;

    always_ff @(posedge RATE_CLK)
    begin
        if (!RATE_RST_N)
            state <= TS_IDLE;
        else
        begin
            case (state)
                TS_IDLE:
                    if (txsync_start)
                        state <= TS_INIT;
                TS_INIT:
                    state <= TS_INIT_WAIT;
                TS_INIT_WAIT:
                    if (tx_phinitdone)
                        state <= TS_ALIGN;
                TS_ALIGN:
                    state <= TS_ALIGN_WAIT;
                TS_ALIGN_WAIT:
                    if (tx_phaligndone)
                        state <= TS_IDLE;
                default:
                    state <= TS_IDLE;
            endcase
        end
    end

    assign tx_phinit   = (state == TS_INIT);     // Single-cycle requests.
    assign tx_phalign  = (state == TS_ALIGN);
    assign txsync_done = (state == TS_IDLE);

endmodule

`default_nettype wire

// File: pipe_rate_top.sv
`default_nettype none

module pipe_rate_top
(
    input  wire                               RATE_CLK,
    input  wire                               RATE_RST_N,
    input  wire  [1:0]                        rate_in,
    input  wire                               rxpmaresetdone,
    input  wire                               txratedone,
    input  wire                               rxratedone,
    input  wire                               phystatus,
    output wire  [rate_pkg::DRP_ADDR_W-1:0]   drp_addr,
    output wire                               drp_en,
    output wire                               drp_we,
    output wire  [rate_pkg::DRP_DATA_W-1:0]   drp_di,
    input  wire  [rate_pkg::DRP_DATA_W-1:0]   drp_do,
    input  wire                               drp_rdy,
    output wire                               tx_phinit,
    output wire                               tx_phalign,
    input  wire                               tx_phinitdone,
    input  wire                               tx_phaligndone,
    output wire                               pclk_sel,
    output wire  [2:0]                        rate_out,
    output wire                               rate_done,
    output wire                               rate_idle,
    output rate_pkg::rate_state_t             rate_state
);

    wire drp_start;
    wire drp_x16;
    wire drp_done;
    wire txsync_start;
    wire txsync_done;

    pipe_rate_ctrl i_pipe_rate_ctrl
    (
        .RATE_CLK       (RATE_CLK),
        .RATE_RST_N     (RATE_RST_N),
        .rate_in        (rate_in),
        .drp_done       (drp_done),
        .rxpmaresetdone (rxpmaresetdone),
        .txratedone     (txratedone),
        .rxratedone     (rxratedone),
        .phystatus      (phystatus),
        .txsync_done    (txsync_done),
        .pclk_sel       (pclk_sel),
        .drp_start      (drp_start),
        .drp_x16        (drp_x16),
        .rate_out       (rate_out),
        .txsync_start   (txsync_start),
        .rate_done      (rate_done),
        .rate_idle      (rate_idle),
        .rate_state     (rate_state)
    );

    drp_width_ctrl i_drp_width_ctrl
    (
        .RATE_CLK   (RATE_CLK),
        .RATE_RST_N (RATE_RST_N),
        .drp_start  (drp_start),
        .drp_x16    (drp_x16),
        .drp_done   (drp_done),
        .drp_addr   (drp_addr),
        .drp_en     (drp_en),
        .drp_we     (drp_we),
        .drp_di     (drp_di),
        .drp_do     (drp_do),
        .drp_rdy    (drp_rdy)
    );

    txsync_ctrl i_txsync_ctrl
    (
        .RATE_CLK       (RATE_CLK),
        .RATE_RST_N     (RATE_RST_N),
        .txsync_start   (txsync_start),
        .txsync_done    (txsync_done),
        .tx_phinit      (tx_phinit),
        .tx_phalign     (tx_phalign),
        .tx_phinitdone  (tx_phinitdone),
        .tx_phaligndone (tx_phaligndone)
    );

endmodule

`default_nettype wire

// File: tb_pipe_rate.sv
`default_nettype none

module tb_pipe_rate;

    timeunit 1ns;
    timeprecision 1ps;

    import rate_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int SEED         = 33;
    localparam int NUM_TESTS    = 5;
    localparam int SEQ_CYCLES   = 400;     // Worst-case bound for one rate change.
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = int'(TXDATA_WAIT_MAX) + 1;

    logic                  RATE_CLK;
    logic                  RATE_RST_N;
    logic [1:0]            rate_in;
    logic                  rxpmaresetdone = 1'b1;
    logic                  txratedone     = 1'b0;
    logic                  rxratedone     = 1'b0;
    logic                  phystatus      = 1'b0;
    logic [DRP_ADDR_W-1:0] drp_addr;
    logic                  drp_en;
    logic                  drp_we;
    logic [DRP_DATA_W-1:0] drp_di;
    logic [DRP_DATA_W-1:0] drp_do         = '0;
    logic                  drp_rdy        = 1'b0;
    logic                  tx_phinit;
    logic                  tx_phalign;
    logic                  tx_phinitdone  = 1'b0;
    logic                  tx_phaligndone = 1'b0;
    logic                  pclk_sel;
    logic [2:0]            rate_out;
    logic                  rate_done;
    logic                  rate_idle;
    rate_state_t           rate_state;

    // DRP register model and its write log.
    logic [DRP_DATA_W-1:0] drp_mem [0:511];
    logic [31:0]           fill_rng;
    logic [31:0]           drp_rng;
    logic                  drp_busy = 1'b0;
    logic [2:0]            drp_wait = 3'd0;
    logic                  rd_valid = 1'b0;
    logic [DRP_ADDR_W-1:0] rd_addr  = '0;
    logic [DRP_ADDR_W-1:0] wr_addr_q  [$];
    logic [DRP_DATA_W-1:0] wr_data_q  [$];
    logic [DRP_DATA_W-1:0] wr_prior_q [$];

    logic [31:0] stat_rng;
    logic [31:0] sync_rng;
    logic [2:0]  rate_out_q = 3'd0;
    logic [2:0]  pma_cnt    = 3'd0;
    logic [5:0]  txr_cnt    = 6'd0;
    logic [5:0]  rxr_cnt    = 6'd0;
    logic [5:0]  phy_cnt    = 6'd0;
    logic        txr_seen   = 1'b0;
    logic        rxr_seen   = 1'b0;
    logic        phy_seen   = 1'b0;
    logic [3:0]  init_cnt   = 4'd0;
    logic [3:0]  align_cnt  = 4'd0;

    // Event history gathered by the monitor.
    int          cycle         = 0;
    rate_state_t prev_state    = ST_IDLE;
    logic        pclk_last     = 1'b0;
    logic [2:0]  rate_out_last = 3'd0;
    int          done_count    = 0;
    int          drp_en_count  = 0;
    int          state_changes = 0;
    int          phinit_count  = 0;
    int          phalign_count = 0;
    int          phinit_cycle  = 0;
    int          phalign_cycle = 0;
    int          req_cycle     = 0;
    int          wait_len      = 0;
    int          pclk_cycle    = 0;
    int          rate_cycle    = 0;

    int errors         = 0;
    int monitor_errors = 0;
    int drp_errors     = 0;

    pipe_rate_top i_pipe_rate_top
    (
        .RATE_CLK       (RATE_CLK),
        .RATE_RST_N     (RATE_RST_N),
        .rate_in        (rate_in),
        .rxpmaresetdone (rxpmaresetdone),
        .txratedone     (txratedone),
        .rxratedone     (rxratedone),
        .phystatus      (phystatus),
        .drp_addr       (drp_addr),
        .drp_en         (drp_en),
        .drp_we         (drp_we),
        .drp_di         (drp_di),
        .drp_do         (drp_do),
        .drp_rdy        (drp_rdy),
        .tx_phinit      (tx_phinit),
        .tx_phalign     (tx_phalign),
        .tx_phinitdone  (tx_phinitdone),
        .tx_phaligndone (tx_phaligndone),
        .pclk_sel       (pclk_sel),
        .rate_out       (rate_out),
        .rate_done      (rate_done),
        .rate_idle      (rate_idle),
        .rate_state     (rate_state)
    );

    initial RATE_CLK = 1'b0;
    always #(CLK_PERIOD / 2) RATE_CLK = ~RATE_CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge RATE_CLK)
    begin
        drp_rdy <= 1'b0;
        if (!RATE_RST_N)
        begin
            fill_rng = SEED;
            drp_rng  = SEED ^ 32'h0000_0300;     // Own stream for access delays.
            for (int a = 0; a < 512; a++)
            begin
                fill_rng   = xorshift32(fill_rng);
                drp_mem[a] = fill_rng[15:0] ^ 16'(a);
            end
            drp_busy <= 1'b0;
            rd_valid <= 1'b0;
        end
        else if (drp_busy)
        begin
            if (drp_en)
            begin
                drp_errors++;
                $display("ERROR: a DRP access was issued while another was outstanding");
            end
            if (drp_wait == 3'd0)
            begin
                drp_rdy  <= 1'b1;
                drp_busy <= 1'b0;
            end
            else
                drp_wait <= drp_wait - 3'd1;
        end
        else if (drp_en)
        begin
            drp_rng = xorshift32(drp_rng);
            drp_busy <= 1'b1;
            drp_wait <= drp_rng[2:0];            // Ready after 1 to 8 cycles.
            if (drp_we)
            begin
                if (!rd_valid || (rd_addr != drp_addr))
                begin
                    drp_errors++;
                    $display("ERROR: DRP write to 0x%0h was not preceded by a read of it",
                             drp_addr);
                end
                wr_addr_q.push_back(drp_addr);
                wr_data_q.push_back(drp_di);
                wr_prior_q.push_back(drp_mem[drp_addr]);
                drp_mem[drp_addr] = drp_di;
                rd_valid <= 1'b0;
            end
            else
            begin
                drp_do   <= drp_mem[drp_addr];
                rd_valid <= 1'b1;
                rd_addr  <= drp_addr;
            end
        end
    end

    // PMA reset and rate-done responses of the transceiver.
    always @(posedge RATE_CLK)
    begin
        txratedone <= 1'b0;
        rxratedone <= 1'b0;
        phystatus  <= 1'b0;
        if (!RATE_RST_N)
        begin
            stat_rng = SEED ^ 32'h0000_0100;
            rate_out_q     <= 3'd0;
            pma_cnt        <= 3'd0;
            txr_cnt        <= 6'd0;
            rxr_cnt        <= 6'd0;
            phy_cnt        <= 6'd0;
            rxpmaresetdone <= 1'b1;
        end
        else if (rate_out != rate_out_q)
        begin
            stat_rng = xorshift32(stat_rng);
            rate_out_q <= rate_out;
            pma_cnt    <= 3'd2 + {1'b0, stat_rng[1:0]};
            txr_cnt    <= 6'd3 + {1'b0, stat_rng[9:5]};     // Independent offsets.
            rxr_cnt    <= 6'd3 + {1'b0, stat_rng[14:10]};
            phy_cnt    <= 6'd3 + {1'b0, stat_rng[19:15]};
            txr_seen   <= 1'b0;
            rxr_seen   <= 1'b0;
            phy_seen   <= 1'b0;
        end
        else
        begin
            rxpmaresetdone <= (pma_cnt == 3'd0);
            if (pma_cnt != 3'd0)
                pma_cnt <= pma_cnt - 3'd1;
            if (txr_cnt != 6'd0)
                txr_cnt <= txr_cnt - 6'd1;
            if (rxr_cnt != 6'd0)
                rxr_cnt <= rxr_cnt - 6'd1;
            if (phy_cnt != 6'd0)
                phy_cnt <= phy_cnt - 6'd1;
            if (txr_cnt == 6'd1)
            begin
                txratedone <= 1'b1;
                txr_seen   <= 1'b1;
            end
            if (rxr_cnt == 6'd1)
            begin
                rxratedone <= 1'b1;
                rxr_seen   <= 1'b1;
            end
            if (phy_cnt == 6'd1)
            begin
                phystatus <= 1'b1;
                phy_seen  <= 1'b1;
            end
        end
    end

    always @(posedge RATE_CLK)
    begin
        tx_phinitdone  <= 1'b0;
        tx_phaligndone <= 1'b0;
        if (!RATE_RST_N)
        begin
            sync_rng = SEED ^ 32'h0000_0200;
            init_cnt  <= 4'd0;
            align_cnt <= 4'd0;
        end
        else
        begin
            if (tx_phinit || tx_phalign)
                sync_rng = xorshift32(sync_rng);
            if (tx_phinit)
                init_cnt <= {1'b0, sync_rng[2:0]} + 4'd1;
            else if (init_cnt != 4'd0)
            begin
                init_cnt <= init_cnt - 4'd1;
                tx_phinitdone <= (init_cnt == 4'd1);
            end
            if (tx_phalign)
                align_cnt <= {1'b0, sync_rng[5:3]} + 4'd1;
            else if (align_cnt != 4'd0)
            begin
                align_cnt <= align_cnt - 4'd1;
                tx_phaligndone <= (align_cnt == 4'd1);
            end
        end
    end

    always @(posedge RATE_CLK)
    begin
        cycle         <= cycle + 1;
        prev_state    <= rate_state;
        pclk_last     <= pclk_sel;
        rate_out_last <= rate_out;
        if (RATE_RST_N)
        begin
            if (rate_done)
                done_count <= done_count + 1;
            if (drp_en)
                drp_en_count <= drp_en_count + 1;
            if (rate_state != prev_state)
                state_changes <= state_changes + 1;
            if (tx_phinit)
            begin
                phinit_count <= phinit_count + 1;
                phinit_cycle <= cycle;
            end
            if (tx_phalign)
            begin
                phalign_count <= phalign_count + 1;
                phalign_cycle <= cycle;
            end
            if ((rate_state == ST_TXDATA_WAIT) && (prev_state != ST_TXDATA_WAIT))
            begin
                req_cycle <= cycle;
                wait_len  <= 1;
            end
            else if (rate_state == ST_TXDATA_WAIT)
                wait_len <= wait_len + 1;
            if (pclk_sel != pclk_last)
                pclk_cycle <= cycle;
            if (rate_out != rate_out_last)
                rate_cycle <= cycle;
            if ((rate_state == ST_TXSYNC_START) && (prev_state != ST_TXSYNC_START) &&
                !(txr_seen && rxr_seen && phy_seen))
            begin
                monitor_errors++;
                $display("ERROR: phase alignment started before all rate-done statuses arrived");
            end
        end
    end

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        errors++;
        $display("FAILED %s: %s expected 0x%0h actual 0x%0h", name, what, expected, actual);
    endtask

    task automatic report_error(input string name, input string msg);
        errors++;
        $display("ERROR: %s: %s", name, msg);
    endtask

    task automatic check_reset_state(input string name);
        @(posedge RATE_CLK);
        if (rate_idle !== 1'b1)
            report_mismatch(name, "rate_idle", 32'd1, 32'(rate_idle));
        if (rate_state !== ST_IDLE)
            report_mismatch(name, "rate_state", 32'(ST_IDLE), 32'(rate_state));
        if (pclk_sel !== 1'b0)
            report_mismatch(name, "pclk_sel", 32'd0, 32'(pclk_sel));
        if (rate_out !== 3'd0)
            report_mismatch(name, "rate_out", 32'd0, 32'(rate_out));
        if (rate_done !== 1'b0)
            report_mismatch(name, "rate_done", 32'd0, 32'(rate_done));
        if ((drp_en !== 1'b0) || (drp_we !== 1'b0))
            report_mismatch(name, "drp_en/drp_we", 32'd0, 32'({drp_en, drp_we}));
        if ((tx_phinit !== 1'b0) || (tx_phalign !== 1'b0))
            report_mismatch(name, "tx_phinit/tx_phalign", 32'd0, 32'({tx_phinit, tx_phalign}));
    endtask

    // Two width writes at x16, then two at x20, outside bits kept.
    task automatic check_drp_writes(input string name, input int first);
        logic [DRP_ADDR_W-1:0] exp_addr;
        logic [DRP_DATA_W-1:0] exp_data;
        if (wr_addr_q.size() - first != 4)
            report_mismatch(name, "DRP write count", 32'd4, 32'(wr_addr_q.size() - first));
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                exp_addr = (i % 2 == 0) ? DRP_TX_WIDTH_ADDR : DRP_RX_WIDTH_ADDR;
                exp_data = (wr_prior_q[first + i] & ~WIDTH_FIELD_MASK) |
                           ((i < 2) ? WIDTH_X16 : WIDTH_X20);
                if (wr_addr_q[first + i] !== exp_addr)
                    report_mismatch(name, "DRP write address", 32'(exp_addr),
                                    32'(wr_addr_q[first + i]));
                if (wr_data_q[first + i] !== exp_data)
                    report_mismatch(name, "DRP write data", 32'(exp_data),
                                    32'(wr_data_q[first + i]));
            end
        end
    endtask

    task automatic run_rate_change(input string name, input logic [1:0] new_rate);
        int          done0;
        int          phinit0;
        int          phalign0;
        int          wr0;
        int          drive_cycle;
        int          done_cycle;
        int          timer;
        logic        got_done;
        logic [2:0]  exp_rate;
        logic        exp_pclk;
        exp_rate = (new_rate == RATE_GEN2) ? 3'd1 : 3'd0;
        exp_pclk = (new_rate == RATE_GEN2);
        @(posedge RATE_CLK);
        done0       = done_count;
        phinit0     = phinit_count;
        phalign0    = phalign_count;
        wr0         = wr_addr_q.size();
        drive_cycle = cycle;
        done_cycle  = 0;
        rate_in <= new_rate;
        got_done = 1'b0;
        timer    = 0;
        while (!got_done && (timer < SEQ_CYCLES))
        begin
            @(posedge RATE_CLK);
            timer++;
            if (rate_done)
            begin
                got_done   = 1'b1;
                done_cycle = cycle;
            end
        end
        if (!got_done)
            report_error(name, "rate_done never pulsed after the rate request");
        else
        begin
            @(posedge RATE_CLK);
            if (rate_idle !== 1'b1)
                report_mismatch(name, "rate_idle after rate_done", 32'd1, 32'(rate_idle));
            if (rate_out !== exp_rate)
                report_mismatch(name, "rate_out", 32'(exp_rate), 32'(rate_out));
            if (pclk_sel !== exp_pclk)
                report_mismatch(name, "pclk_sel", 32'(exp_pclk), 32'(pclk_sel));
            if (req_cycle - drive_cycle != 3)
                report_mismatch(name, "request latency", 32'd3, 32'(req_cycle - drive_cycle));
            if (wait_len != DRAIN_CYCLES)
                report_mismatch(name, "TX drain cycles", 32'(DRAIN_CYCLES), 32'(wait_len));
            if ((pclk_cycle <= req_cycle) || (pclk_cycle >= rate_cycle))
                report_error(name, "pclk_sel did not switch between request and rate_out");
            if (rate_cycle - req_cycle < DRAIN_CYCLES)
                report_error(name, "rate_out changed before the TX drain wait ended");
            if ((phinit_cycle <= drive_cycle) || (phinit_cycle >= phalign_cycle) ||
                (phalign_cycle >= done_cycle))
                report_error(name, "tx_phinit and tx_phalign not in order before rate_done");
            repeat (20) @(posedge RATE_CLK);
            if (done_count - done0 != 1)
                report_mismatch(name, "rate_done pulses", 32'd1, 32'(done_count - done0));
            if (phinit_count - phinit0 != 1)
                report_mismatch(name, "tx_phinit pulses", 32'd1, 32'(phinit_count - phinit0));
            if (phalign_count - phalign0 != 1)
                report_mismatch(name, "tx_phalign pulses", 32'd1,
                                32'(phalign_count - phalign0));
            check_drp_writes(name, wr0);
        end
    endtask

    task automatic check_no_request(input string name);
        int done0;
        int en0;
        int chg0;
        @(posedge RATE_CLK);
        done0 = done_count;
        en0   = drp_en_count;
        chg0  = state_changes;
        repeat (200) @(posedge RATE_CLK);
        if (done_count != done0)
            report_mismatch(name, "rate_done pulses", 32'd0, 32'(done_count - done0));
        if (drp_en_count != en0)
            report_mismatch(name, "drp_en pulses", 32'd0, 32'(drp_en_count - en0));
        if (state_changes != chg0)
            report_mismatch(name, "rate_state changes", 32'd0, 32'(state_changes - chg0));
        if (rate_state !== ST_IDLE)
            report_mismatch(name, "rate_state", 32'(ST_IDLE), 32'(rate_state));
    endtask

    initial
    begin
        #((NUM_TESTS * SEQ_CYCLES + RESET_CYCLES) * CLK_PERIOD);
        $display("ERROR: watchdog expired, a test stopped making progress");
        $display("=== FAIL ===");
        $finish;
    end

    initial
    begin
        RATE_RST_N = 1'b0;
        rate_in    = RATE_GEN1;
        repeat (RESET_CYCLES) @(posedge RATE_CLK);
        RATE_RST_N <= 1'b1;
        check_reset_state("reset_state");
        run_rate_change("gen1_to_gen2", RATE_GEN2);
        run_rate_change("gen2_to_gen1", RATE_GEN1);
        run_rate_change("gen1_to_gen2_again", RATE_GEN2);
        check_no_request("no_request");
        $display("Errors: %0d test, %0d monitor, %0d DRP model", errors, monitor_errors,
                 drp_errors);
        if (errors + monitor_errors + drp_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rate_pkg.sv
pipe_rate_ctrl.sv
drp_width_ctrl.sv
txsync_ctrl.sv
pipe_rate_top.sv
tb_pipe_rate.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing
TOP       := tb_pipe_rate
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
